//--- filelist.f
+incdir+include
logic/nes_video_pkg.sv
logic/pixel_stream_if.sv
logic/bg_tile_renderer.sv
logic/pixel_fifo.sv
logic/video_timing_palette.sv
logic/nes_video_top.sv
sim/nes_video_asserts.sv
sim/tb_nes_video.sv

//--- include/nes_palette.svh
`ifndef NES_PALETTE_SVH
`define NES_PALETTE_SVH

// approximate NES system palette, packed as rrr_ggg_bb
// entries x_d to x_f are the unused black slots
function automatic rgb332_t nes_palette_rgb(input palette_idx_t idx);
  case (idx)
    6'h00: return 8'b011_011_01;
    6'h01: return 8'b001_000_10;
    6'h02: return 8'b000_000_10;
    6'h03: return 8'b010_000_10;
    6'h04: return 8'b100_000_01;
    6'h05: return 8'b101_000_00;
    6'h06: return 8'b101_000_00;
    6'h07: return 8'b011_000_00;
    6'h08: return 8'b010_001_00;
    6'h09: return 8'b000_010_00;
    6'h0a: return 8'b000_010_00;
    6'h0b: return 8'b000_001_00;
    6'h0c: return 8'b000_001_01;

    6'h10: return 8'b101_101_10;
    6'h11: return 8'b000_011_11;
    6'h12: return 8'b001_001_11;
    6'h13: return 8'b100_000_11;
    6'h14: return 8'b101_000_10;
    6'h15: return 8'b111_000_01;
    6'h16: return 8'b110_001_00;
    6'h17: return 8'b110_010_00;
    6'h18: return 8'b100_011_00;
    6'h19: return 8'b000_100_00;
    6'h1a: return 8'b000_101_00;
    6'h1b: return 8'b000_100_00;
    6'h1c: return 8'b000_100_10;

    6'h20: return 8'b111_111_11;
    6'h21: return 8'b001_101_11;
    6'h22: return 8'b010_100_11;
    6'h23: return 8'b101_100_11;
    6'h24: return 8'b111_011_11;
    6'h25: return 8'b111_011_10;
    6'h26: return 8'b111_011_01;
    6'h27: return 8'b111_100_00;
    6'h28: return 8'b111_101_00;
    6'h29: return 8'b100_110_00;
    6'h2a: return 8'b010_110_01;
    6'h2b: return 8'b010_111_10;
    6'h2c: return 8'b000_111_11;

    // pastel row
    6'h30: return 8'b111_111_11;
    6'h31: return 8'b101_111_11;
    6'h32: return 8'b110_110_11;
    6'h33: return 8'b110_110_11;
    6'h34: return 8'b111_110_11;
    6'h35: return 8'b111_110_11;
    6'h36: return 8'b111_101_10;
    6'h37: return 8'b111_110_10;
    6'h38: return 8'b111_111_10;
    6'h39: return 8'b111_111_10;
    6'h3a: return 8'b101_111_10;
    6'h3b: return 8'b101_111_11;
    6'h3c: return 8'b100_111_11;

    default: return 8'h00;  // black
  endcase
endfunction

`endif

//--- logic/bg_tile_renderer.sv
`timescale 1ns/1ps

module bg_tile_renderer import nes_video_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         i_frame_start,
  input  logic         i_cfg_we,
  input  tile_addr_t   i_cfg_addr,
  input  palette_idx_t i_cfg_idx,
  pixel_stream_if.src  o_pix
);

  palette_idx_t live_tbl   [TILE_ENTRIES];
  palette_idx_t shadow_tbl [TILE_ENTRIES];

  logic       r_wait;     // idle until the next frame start
  coord_t     r_col;
  coord_t     r_row;
  tile_addr_t tile;
  logic       xfer;
  logic       take_frame;

  assign take_frame = i_frame_start && r_wait;
  assign xfer       = o_pix.valid && o_pix.ready;

  // tile index walks diagonally, 8x8 pixel blocks
  assign tile = r_col[7:3] + r_row[7:3];  // wraps mod 32

  assign o_pix.valid = !r_wait;
  assign o_pix.idx   = shadow_tbl[tile];
  assign o_pix.eol   = (r_col == coord_t'(IMAGE_WIDTH - 1));
  assign o_pix.eof   = o_pix.eol && (r_row == coord_t'(IMAGE_HEIGHT - 1));

  // host side table
  always_ff @(posedge clk) begin
    if (i_cfg_we) begin
      live_tbl[i_cfg_addr] <= i_cfg_idx;
    end
  end

  // one table state per frame
  always_ff @(posedge clk) begin
    if (take_frame) begin
      shadow_tbl <= live_tbl;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_wait <= 1'b1;
      r_col  <= '0;
      r_row  <= '0;
    end else if (take_frame) begin
      r_wait <= 1'b0;
      r_col  <= '0;
      r_row  <= '0;
    end else if (xfer) begin
      if (o_pix.eol) begin
        r_col <= '0;
        if (o_pix.eof) begin
          r_row  <= '0;
          r_wait <= 1'b1;  // frame done
        end else begin
          r_row <= r_row + 1'b1;
        end
      end else begin
        r_col <= r_col + 1'b1;
      end
    end
  end

endmodule

//--- logic/nes_video_pkg.sv
package nes_video_pkg;

  typedef logic [5:0] palette_idx_t;  // system palette index
  typedef logic [7:0] rgb332_t;       // rrr_ggg_bb
  typedef logic [8:0] coord_t;        // raster counter
  typedef logic [9:0] nes_coord_t;    // coordinate as seen by the PPU
  typedef logic [4:0] tile_addr_t;    // tile table index

  // full raster, in pixel strobes
  localparam int FRAME_WIDTH  = 400;
  localparam int FRAME_HEIGHT = 260;

  // visible picture
  localparam int IMAGE_WIDTH  = 256;
  localparam int IMAGE_HEIGHT = 240;

  localparam int X_FRONT_PORCH = 32;
  localparam int X_BACK_PORCH  = 32;
  localparam int X_VIS_END     = X_FRONT_PORCH + IMAGE_WIDTH;  // first column past the picture
  localparam int X_MID         = FRAME_WIDTH / 2;              // next-y update point

  // vblank set and clear points
  localparam int VBLANK_START_X = 365;
  localparam int VBLANK_START_Y = 238;
  localparam int VBLANK_END_X   = 32;
  localparam int VBLANK_END_Y   = 259;

  localparam int CLK_DIV   = 4;  // clocks per pixel
  localparam int CLK_DIV_W = $clog2(CLK_DIV);

  localparam int TILE_ENTRIES = 32;

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

  `include "nes_palette.svh"

endpackage

//--- logic/nes_video_top.sv
`timescale 1ns/1ps

module nes_video_top import nes_video_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         i_cfg_we,
  input  tile_addr_t   i_cfg_addr,
  input  palette_idx_t i_cfg_idx,
  output logic         o_pix_pulse,
  output logic         o_hsync,
  output logic         o_vsync,
  output logic         o_vblank,
  output logic         o_underrun,
  output logic [2:0]   o_r,
  output logic [2:0]   o_g,
  output logic [1:0]   o_b,
  output nes_coord_t   o_nes_x,
  output nes_coord_t   o_nes_y,
  output nes_coord_t   o_nes_y_next
);

  logic frame_start;

  pixel_stream_if rend_if ();  // renderer to fifo
  pixel_stream_if disp_if ();  // fifo to display

  bg_tile_renderer u_renderer (
    .clk           (clk),
    .rst           (rst),
    .i_frame_start (frame_start),
    .i_cfg_we      (i_cfg_we),
    .i_cfg_addr    (i_cfg_addr),
    .i_cfg_idx     (i_cfg_idx),
    .o_pix         (rend_if.src)
  );

  pixel_fifo u_fifo (
    .clk   (clk),
    .rst   (rst),
    .i_in  (rend_if.dst),
    .o_out (disp_if.src)
  );

  video_timing_palette u_timing (
    .clk           (clk),
    .rst           (rst),
    .i_pix         (disp_if.dst),
    .o_pix_pulse   (o_pix_pulse),
    .o_hsync       (o_hsync),
    .o_vsync       (o_vsync),
    .o_vblank      (o_vblank),
    .o_frame_start (frame_start),
    .o_underrun    (o_underrun),
    .o_r           (o_r),
    .o_g           (o_g),
    .o_b           (o_b),
    .o_nes_x       (o_nes_x),
    .o_nes_y       (o_nes_y),
    .o_nes_y_next  (o_nes_y_next)
  );

endmodule

//--- logic/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import nes_video_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  pixel_stream_if.dst i_in,
  pixel_stream_if.src o_out
);

  palette_idx_t mem_idx [FIFO_DEPTH];
  logic         mem_eol [FIFO_DEPTH];
  logic         mem_eof [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] r_wr_ptr;
  logic [FIFO_PTR_W-1:0] r_rd_ptr;
  logic [FIFO_CNT_W-1:0] r_count;

  logic full;
  logic push;
  logic pop;

  assign full = (r_count == FIFO_CNT_W'(FIFO_DEPTH));

  // a pop frees the slot for a push in the same clock
  assign i_in.ready = !full || o_out.ready;
  assign push       = i_in.valid && i_in.ready;
  assign pop        = o_out.valid && o_out.ready;

  assign o_out.valid = (r_count != '0);
  assign o_out.idx   = mem_idx[r_rd_ptr];
  assign o_out.eol   = mem_eol[r_rd_ptr];
  assign o_out.eof   = mem_eof[r_rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_idx[r_wr_ptr] <= i_in.idx;
      mem_eol[r_wr_ptr] <= i_in.eol;
      mem_eof[r_wr_ptr] <= i_in.eof;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;  // depth is a power of two
      end
      if (pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

endmodule

//--- logic/pixel_stream_if.sv
`timescale 1ns/1ps

interface pixel_stream_if import nes_video_pkg::*; ();

  logic         valid;
  logic         ready;
  palette_idx_t idx;
  logic         eol;  // last pixel of a line
  logic         eof;  // last pixel of the frame

  modport src (
    output valid,
    output idx,
    output eol,
    output eof,
    input  ready
  );

  modport dst (
    input  valid,
    input  idx,
    input  eol,
    input  eof,
    output ready
  );

endinterface

//--- logic/video_timing_palette.sv
`timescale 1ns/1ps

module video_timing_palette import nes_video_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  pixel_stream_if.dst i_pix,
  output logic        o_pix_pulse,
  output logic        o_hsync,
  output logic        o_vsync,
  output logic        o_vblank,
  output logic        o_frame_start,
  output logic        o_underrun,
  output logic [2:0]  o_r,
  output logic [2:0]  o_g,
  output logic [1:0]  o_b,
  output nes_coord_t  o_nes_x,
  output nes_coord_t  o_nes_y,
  output nes_coord_t  o_nes_y_next
);

  logic [CLK_DIV_W-1:0] r_div;
  coord_t     r_x;
  coord_t     r_y;
  coord_t     nx;          // raster position the next strobe enters
  coord_t     ny;
  logic       r_active;    // renderer has been started
  rgb332_t    r_rgb;
  nes_coord_t r_y_next;
  logic       next_vis;
  logic       exp_eol;
  logic       exp_eof;
  logic       mark_bad;
  logic       pop;

  always_comb begin
    nx = r_x + 1'b1;
    ny = r_y;
    if (r_x == coord_t'(FRAME_WIDTH - 1)) begin
      nx = '0;
      ny = (r_y == coord_t'(FRAME_HEIGHT - 1)) ? '0 : r_y + 1'b1;
    end
  end

  assign next_vis = (ny < coord_t'(IMAGE_HEIGHT)) &&
                    (nx >= coord_t'(X_FRONT_PORCH)) && (nx < coord_t'(X_VIS_END));

  // where the stream marks ought to land
  assign exp_eol  = (nx == coord_t'(X_VIS_END - 1));
  assign exp_eof  = exp_eol && (ny == coord_t'(IMAGE_HEIGHT - 1));
  assign mark_bad = (i_pix.eol != exp_eol) || (i_pix.eof != exp_eof);

  assign pop         = o_pix_pulse && next_vis && r_active;
  assign i_pix.ready = pop;

  // pixel strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      r_div       <= '0;
      o_pix_pulse <= 1'b0;
    end else begin
      o_pix_pulse <= (r_div == CLK_DIV_W'(CLK_DIV - 1));
      r_div       <= (r_div == CLK_DIV_W'(CLK_DIV - 1)) ? '0 : r_div + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_x           <= '0;
      r_y           <= '0;
      o_vblank      <= 1'b0;
      o_frame_start <= 1'b0;
      r_active      <= 1'b0;
      r_y_next      <= '0;
    end else begin
      o_frame_start <= 1'b0;
      if (o_pix_pulse) begin
        r_x <= nx;
        r_y <= ny;
        if (nx == coord_t'(VBLANK_START_X) && ny == coord_t'(VBLANK_START_Y)) begin
          o_vblank <= 1'b1;
        end
        if (nx == coord_t'(VBLANK_END_X) && ny == coord_t'(VBLANK_END_Y)) begin
          o_vblank      <= 1'b0;
          o_frame_start <= 1'b1;  // kicks off the renderer
          r_active      <= 1'b1;
        end
        if (nx == coord_t'(X_MID)) begin
          r_y_next <= nes_coord_t'(ny) + 1'b1;
        end
      end
    end
  end

  // colour out, one clock behind the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      r_rgb      <= '0;
      o_underrun <= 1'b0;
    end else if (o_pix_pulse) begin
      r_rgb <= '0;
      if (pop) begin
        if (i_pix.valid) begin
          r_rgb <= nes_palette_rgb(i_pix.idx);
          if (mark_bad) begin
            o_underrun <= 1'b1;  // stream out of step with raster
          end
        end else begin
          o_underrun <= 1'b1;
        end
      end
    end
  end

  assign o_vsync = (r_y < coord_t'(IMAGE_HEIGHT));
  // picture plus back porch
  assign o_hsync = o_vsync && (r_x >= coord_t'(X_FRONT_PORCH)) &&
                   (r_x < coord_t'(X_VIS_END + X_BACK_PORCH));

  assign o_nes_x      = nes_coord_t'(r_x) - nes_coord_t'(X_FRONT_PORCH);
  assign o_nes_y      = nes_coord_t'(r_y);
  assign o_nes_y_next = r_y_next;

  assign o_r = r_rgb[7:5];
  assign o_g = r_rgb[4:2];
  assign o_b = r_rgb[1:0];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, exit status carries the result
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f filelist.f --top-module tb_nes_video \
  -o tb_nes_video \
  && ./obj_dir/tb_nes_video \
  || { echo "simulation run failed"; exit 1; }

//--- sim/nes_video_asserts.sv
`timescale 1ns/1ps

module nes_video_asserts (
  input logic       clk,
  input logic       rst,
  input logic       i_pix_pulse,
  input logic       i_underrun,
  input logic       i_hsync,
  input logic [2:0] i_r,
  input logic [2:0] i_g,
  input logic [1:0] i_b
);

  // strobe lasts a single clock
  strobe_single: assert property (@(posedge clk) disable iff (rst)
    i_pix_pulse |=> !i_pix_pulse)
    else $error("pixel strobe high on two clocks in a row");

  no_underrun: assert property (@(posedge clk) disable iff (rst)
    !$rose(i_underrun))
    else $error("underrun flag rose");

  black_outside: assert property (@(posedge clk) disable iff (rst)
    !i_hsync |-> ({i_r, i_g, i_b} == 8'h00))  // blanked region
    else $error("colour output while hsync low");

endmodule

bind video_timing_palette nes_video_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .i_pix_pulse (o_pix_pulse),
  .i_underrun  (o_underrun),
  .i_hsync     (o_hsync),
  .i_r         (o_r),
  .i_g         (o_g),
  .i_b         (o_b)
);

//--- sim/tb_nes_video.sv
`timescale 1ns/1ps

module tb_nes_video import nes_video_pkg::*; ();

  typedef palette_idx_t [TILE_ENTRIES-1:0] tile_table_t;

  localparam int FRAME_CLKS    = FRAME_WIDTH * FRAME_HEIGHT * CLK_DIV;
  localparam int MAX_CYCLES    = 3 * FRAME_CLKS + 20000;  // three frames plus margin

  logic         clk = 1'b0;
  logic         rst;
  logic         cfg_we;
  tile_addr_t   cfg_addr;
  palette_idx_t cfg_idx;

  logic         pix_pulse;
  logic         hsync;
  logic         vsync;
  logic         vblank;
  logic         underrun;
  logic [2:0]   r;
  logic [2:0]   g;
  logic [1:0]   b;
  nes_coord_t   nes_x;
  nes_coord_t   nes_y;
  nes_coord_t   nes_y_next;

  // raster model advanced by the strobes seen
  tile_table_t tbl_frame1;
  tile_table_t tbl_frame2;
  int          pos_x       = 0;
  int          pos_y       = 0;
  int          pic_frame   = 0;  // frame starts seen so far
  int          y_next_exp  = 0;
  int          strobe_gap  = -1;  // clocks since the last strobe
  int          cycles      = 0;
  logic        strobe_seen = 1'b0;

  nes_video_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .i_cfg_we     (cfg_we),
    .i_cfg_addr   (cfg_addr),
    .i_cfg_idx    (cfg_idx),
    .o_pix_pulse  (pix_pulse),
    .o_hsync      (hsync),
    .o_vsync      (vsync),
    .o_vblank     (vblank),
    .o_underrun   (underrun),
    .o_r          (r),
    .o_g          (g),
    .o_b          (b),
    .o_nes_x      (nes_x),
    .o_nes_y      (nes_y),
    .o_nes_y_next (nes_y_next)
  );

  always #5 clk = ~clk;

  // tile rule followed by the system palette lookup
  function automatic rgb332_t ref_pixel(input tile_table_t tbl, input int x, input int y);
    int tile;
    tile = (x / 8 + y / 8) % TILE_ENTRIES;
    return nes_palette_rgb(tbl[tile]);
  endfunction

  function automatic logic in_picture(input int x, input int y);
    return (y < IMAGE_HEIGHT) && (x >= X_FRONT_PORCH) && (x < X_FRONT_PORCH + IMAGE_WIDTH);
  endfunction

  // picture columns plus the back porch on picture lines
  function automatic logic expected_hsync(input int x, input int y);
    return (y < IMAGE_HEIGHT) && (x >= X_FRONT_PORCH) &&
           (x < X_FRONT_PORCH + IMAGE_WIDTH + X_BACK_PORCH);
  endfunction

  function automatic logic expected_vblank(input int x, input int y);
    logic set_part;
    logic clr_part;
    set_part = (y > VBLANK_START_Y) || (y == VBLANK_START_Y && x >= VBLANK_START_X);
    clr_part = (y == VBLANK_END_Y) && (x >= VBLANK_END_X);
    return set_part && !clr_part;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // random table into the live copy at one entry per clock
  task automatic load_table(output tile_table_t tbl);
    int i;
    for (i = 0; i < TILE_ENTRIES; i++) begin
      tbl[i] = palette_idx_t'($urandom);
      @(negedge clk);
      cfg_we   = 1'b1;
      cfg_addr = tile_addr_t'(i);
      cfg_idx  = tbl[i];
    end
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  always @(negedge clk) begin : compare_proc
    rgb332_t     exp_rgb;
    tile_table_t cur_tbl;
    string       pix_name;
    if (strobe_seen) begin
      pos_x = pos_x + 1;
      if (pos_x == FRAME_WIDTH) begin
        pos_x = 0;
        pos_y = (pos_y == FRAME_HEIGHT - 1) ? 0 : pos_y + 1;
      end
      if (pos_x == VBLANK_END_X && pos_y == VBLANK_END_Y) begin
        pic_frame = pic_frame + 1;  // renderer kicked here
      end
      if (pos_x == FRAME_WIDTH / 2) begin
        y_next_exp = pos_y + 1;
      end

      check_val("nes_x", (pos_x - X_FRONT_PORCH) & 'h3ff, 32'(nes_x));
      check_val("nes_y", pos_y, 32'(nes_y));
      check_val("nes_y_next", y_next_exp, 32'(nes_y_next));
      check_val("vblank", 32'(expected_vblank(pos_x, pos_y)), 32'(vblank));
      check_val("vsync", 32'(pos_y < IMAGE_HEIGHT), 32'(vsync));
      check_val("hsync", 32'(expected_hsync(pos_x, pos_y)), 32'(hsync));
      check_val("underrun", 0, 32'(underrun));

      exp_rgb  = '0;
      pix_name = "blanking";
      if (in_picture(pos_x, pos_y) && (pic_frame == 1 || pic_frame == 2)) begin
        cur_tbl  = (pic_frame == 1) ? tbl_frame1 : tbl_frame2;
        exp_rgb  = ref_pixel(cur_tbl, pos_x - X_FRONT_PORCH, pos_y);
        pix_name = $sformatf("frame%0d_pixel x=%0d y=%0d", pic_frame,
                             pos_x - X_FRONT_PORCH, pos_y);
      end
      check_val(pix_name, 32'(exp_rgb), 32'({r, g, b}));
    end
    strobe_seen = pix_pulse && !rst;

    // strobe spacing in clocks
    if (strobe_seen) begin
      if (strobe_gap >= 0) begin
        check_val("strobe_period", CLK_DIV, strobe_gap);
      end
      strobe_gap = 0;
    end
    if (strobe_gap >= 0) begin
      strobe_gap = strobe_gap + 1;
    end
  end

  always @(negedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: frame 2 did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst      = 1'b1;
    cfg_we   = 1'b0;
    cfg_addr = '0;
    cfg_idx  = '0;
    void'($urandom(55877));

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    load_table(tbl_frame1);  // well before the first frame start

    // halfway down frame 1
    while (!(pic_frame == 1 && pos_y == IMAGE_HEIGHT / 2)) begin
      @(negedge clk);
    end
    load_table(tbl_frame2);

    while (pic_frame < 3) begin
      @(negedge clk);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule
